// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_mem_stage
FILELIST  ?= sources.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
PASS_STR  ?= === PASS ===
VFLAGS    ?= --timing --assert

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

build:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(OBJ_DIR)

# the log decides pass or fail, not the exit status of the binary
sim: build
	-./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q -- "$(PASS_STR)" $(LOG); then \
		echo "simulation passed"; \
	else \
		echo "simulation failed"; \
		exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: load_align.sv
`timescale 1ns/1ps

module load_align import mem_pkg::*; (
    input  ld_kind_t    ld_kind,
    input  logic [1:0]  ld_offset,
    input  logic [31:0] rt_value,
    input  rdata_u      rdata,
    output logic [31:0] mem_result
);

    logic [7:0]  sel_byte;
    logic [15:0] sel_half;
    logic [31:0] lwl_result;
    logic [31:0] lwr_result;

    assign sel_byte = rdata.b[ld_offset];
    assign sel_half = rdata.h[ld_offset[1]];

    // lwl: low read bytes go on top, rt fills below
    always_comb begin
        case (ld_offset)
            2'd0:    lwl_result = {rdata.b[0], rt_value[23:0]};
            2'd1:    lwl_result = {rdata.h[0], rt_value[15:0]};
            2'd2:    lwl_result = {rdata.b[2], rdata.h[0], rt_value[7:0]};
            default: lwl_result = rdata;
        endcase
    end

    // lwr: high read bytes go below, rt kept on top
    always_comb begin
        case (ld_offset)
            2'd0:    lwr_result = rdata;
            2'd1:    lwr_result = {rt_value[31:24], rdata.h[1], rdata.b[1]};
            2'd2:    lwr_result = {rt_value[31:16], rdata.h[1]};
            default: lwr_result = {rt_value[31:8], rdata.b[3]};
        endcase
    end

    always_comb begin
        case (ld_kind)
            LD_B: begin
                mem_result = {{24{sel_byte[7]}}, sel_byte};
            end
            LD_BU: begin
                mem_result = {24'd0, sel_byte};
            end
            LD_H: begin
                mem_result = {{16{sel_half[15]}}, sel_half};
            end
            LD_HU: begin
                mem_result = {16'd0, sel_half};
            end
            LD_WL: begin
                mem_result = lwl_result;
            end
            LD_WR: begin
                mem_result = lwr_result;
            end
            default: begin
                mem_result = rdata;
            end
        endcase
    end

endmodule

// File: mem_pkg.sv
package mem_pkg;

    // load flavours decoded in execute
    typedef enum logic [2:0] {
        LD_WORD = 3'd0,
        LD_B    = 3'd1,
        LD_BU   = 3'd2,
        LD_H    = 3'd3,
        LD_HU   = 3'd4,
        LD_WL   = 3'd5,
        LD_WR   = 3'd6
    } ld_kind_t;

    // sram read word, seen as bytes or as halves
    typedef union packed {
        logic [3:0][7:0]  b;
        logic [1:0][15:0] h;
    } rdata_u;

    typedef struct packed {
        logic        refill;
        logic [4:0]  rd;
        logic        inst_tlbr;
        logic        inst_tlbwi;
        logic        inst_mfc0;
        logic        inst_mtc0;
        logic        mem_access;
        logic        pc_error;
        logic [31:0] bad_vaddr;
        logic [4:0]  ex_code;
        logic        eret;
        logic        slot;
        logic        res_from_mem;
        logic        gr_we;
        logic [4:0]  dest;
        logic [31:0] alu_result;
        logic [31:0] pc;
        ld_kind_t    ld_kind;
        // low address bits of the load
        logic [1:0]  ld_offset;
        logic [31:0] rt_value;
    } es_to_ms_t;

    typedef struct packed {
        logic        refill;
        logic [4:0]  rd;
        logic        inst_tlbr;
        logic        inst_tlbwi;
        logic        inst_mfc0;
        logic        inst_mtc0;
        logic        pc_error;
        logic [31:0] bad_vaddr;
        logic [4:0]  ex_code;
        logic        eret;
        logic        slot;
        logic        gr_we;
        logic [4:0]  dest;
        logic [31:0] final_result;
        logic [31:0] pc;
    } ms_to_ws_t;

endpackage

// File: mem_stage.sv
`timescale 1ns/1ps

module mem_stage import mem_pkg::*; (
    input  logic        clk,
    input  logic        reset,
    // handshake with writeback
    input  logic        ws_allowin,
    output logic        ms_allowin,
    // from execute
    input  logic        es_to_ms_valid,
    input  es_to_ms_t   es_to_ms_bus,
    // to writeback
    output logic        ms_to_ws_valid,
    output ms_to_ws_t   ms_to_ws_bus,
    // data sram response
    input  logic        data_sram_data_ok,
    input  logic [31:0] data_sram_rdata,
    // forwarding toward decode
    output logic [4:0]  mem_dest,
    output logic [31:0] mem_dest_data,
    output logic        ms_load_op,
    output logic        inst_mfc0,
    output logic        inst_mtc0,
    // exceptions
    input  logic        ws_ex,
    input  logic        eret,
    output logic        ms_ex,
    output logic        ms_eret
);

    logic        ms_valid;
    logic        ms_ready_go;
    es_to_ms_t   held_bus;
    logic [31:0] mem_result;

    ms_pipe_reg u_pipe_reg (
        .clk               (clk),
        .reset             (reset),
        .es_to_ms_valid    (es_to_ms_valid),
        .es_to_ms_bus      (es_to_ms_bus),
        .ws_allowin        (ws_allowin),
        .ws_ex             (ws_ex),
        .eret              (eret),
        .data_sram_data_ok (data_sram_data_ok),
        .ms_allowin        (ms_allowin),
        .ms_valid          (ms_valid),
        .ms_ready_go       (ms_ready_go),
        .held_bus          (held_bus)
    );

    load_align u_load_align (
        .ld_kind    (held_bus.ld_kind),
        .ld_offset  (held_bus.ld_offset),
        .rt_value   (held_bus.rt_value),
        .rdata      (data_sram_rdata),
        .mem_result (mem_result)
    );

    ms_result_unit u_result_unit (
        .held_bus       (held_bus),
        .ms_valid       (ms_valid),
        .ms_ready_go    (ms_ready_go),
        .mem_result     (mem_result),
        .ms_to_ws_valid (ms_to_ws_valid),
        .ms_to_ws_bus   (ms_to_ws_bus),
        .mem_dest       (mem_dest),
        .mem_dest_data  (mem_dest_data),
        .ms_load_op     (ms_load_op),
        .inst_mfc0      (inst_mfc0),
        .inst_mtc0      (inst_mtc0),
        .ms_ex          (ms_ex),
        .ms_eret        (ms_eret)
    );

endmodule

// File: ms_pipe_reg.sv
`timescale 1ns/1ps
`include "mycpu_config.svh"

module ms_pipe_reg import mem_pkg::*; (
    input  logic      clk,
    input  logic      reset,
    // from execute
    input  logic      es_to_ms_valid,
    input  es_to_ms_t es_to_ms_bus,
    // from writeback
    input  logic      ws_allowin,
    input  logic      ws_ex,
    input  logic      eret,
    // sram response strobe
    input  logic      data_sram_data_ok,
    output logic      ms_allowin,
    output logic      ms_valid,
    output logic      ms_ready_go,
    output es_to_ms_t held_bus
);

    logic flush;

    assign flush = ws_ex || eret;

    // loads and stores wait for the sram, everything else passes at once
    assign ms_ready_go = held_bus.mem_access ? data_sram_data_ok : 1'b1;
    assign ms_allowin  = !ms_valid || (ms_ready_go && ws_allowin);

    always_ff @(posedge clk) begin
        if (reset || flush) begin
            ms_valid <= 1'b0;
        end else if (ms_allowin) begin
            ms_valid <= es_to_ms_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (reset || flush) begin
            held_bus <= '{
                dest:    `REG_NONE,
                ex_code: `NO_EX,
                ld_kind: LD_WORD,
                default: '0
            };
        end else if (es_to_ms_valid && ms_allowin) begin
            held_bus <= es_to_ms_bus;
        end
    end

    // a stalled entry must not move under writeback
    a_held_stable: assert property (
        @(posedge clk) disable iff (reset)
        (ms_valid && !ms_allowin && !flush) |=> $stable(held_bus)
    ) else $error("held bus changed while stalled");

    // sram answers only for an entry that is present
    a_data_ok_valid: assert property (
        @(posedge clk) disable iff (reset)
        data_sram_data_ok |-> ms_valid
    ) else $error("data_ok with empty stage");

endmodule

// File: ms_result_unit.sv
`timescale 1ns/1ps
`include "mycpu_config.svh"

module ms_result_unit import mem_pkg::*; (
    input  es_to_ms_t   held_bus,
    input  logic        ms_valid,
    input  logic        ms_ready_go,
    input  logic [31:0] mem_result,
    output logic        ms_to_ws_valid,
    output ms_to_ws_t   ms_to_ws_bus,
    // toward decode
    output logic [4:0]  mem_dest,
    output logic [31:0] mem_dest_data,
    output logic        ms_load_op,
    output logic        inst_mfc0,
    output logic        inst_mtc0,
    // toward exception logic
    output logic        ms_ex,
    output logic        ms_eret
);

    logic [31:0] final_result;

    assign final_result   = held_bus.res_from_mem ? mem_result : held_bus.alu_result;
    assign ms_to_ws_valid = ms_valid && ms_ready_go;

    always_comb begin
        ms_to_ws_bus.refill       = held_bus.refill;
        ms_to_ws_bus.rd           = held_bus.rd;
        ms_to_ws_bus.inst_tlbr    = held_bus.inst_tlbr;
        ms_to_ws_bus.inst_tlbwi   = held_bus.inst_tlbwi;
        ms_to_ws_bus.inst_mfc0    = held_bus.inst_mfc0;
        ms_to_ws_bus.inst_mtc0    = held_bus.inst_mtc0;
        ms_to_ws_bus.pc_error     = held_bus.pc_error;
        ms_to_ws_bus.bad_vaddr    = held_bus.bad_vaddr;
        ms_to_ws_bus.ex_code      = held_bus.ex_code;
        ms_to_ws_bus.eret         = held_bus.eret;
        ms_to_ws_bus.slot         = held_bus.slot;
        ms_to_ws_bus.gr_we        = held_bus.gr_we;
        ms_to_ws_bus.dest         = held_bus.dest;
        ms_to_ws_bus.final_result = final_result;
        ms_to_ws_bus.pc           = held_bus.pc;
    end

    // forwarding only sees a result once it is final
    assign mem_dest      = ms_valid ? held_bus.dest : 5'd0;
    assign mem_dest_data = ms_to_ws_valid ? final_result : 32'd0;
    assign ms_load_op    = ms_valid && held_bus.res_from_mem;

    assign inst_mfc0 = ms_valid && held_bus.inst_mfc0;
    assign inst_mtc0 = ms_valid && held_bus.inst_mtc0;

    // exception status of the held entry
    assign ms_ex   = (held_bus.ex_code != `NO_EX);
    assign ms_eret = held_bus.eret;

endmodule

// File: mycpu_config.svh
`ifndef MYCPU_CONFIG_SVH
`define MYCPU_CONFIG_SVH

// exception code carried by an instruction that raised nothing
`define NO_EX       5'h00

// destination index parked in the stage register when it is empty
`define REG_NONE    5'd31

// widths fixed by the instruction set
`define WORD_W      32
`define REG_IDX_W   5

`endif

// File: sources.f
+incdir+.
mem_pkg.sv
load_align.sv
ms_pipe_reg.sv
ms_result_unit.sv
mem_stage.sv
tb_mem_stage.sv

// File: tb_mem_stage.sv
`timescale 1ns/1ps
`include "mycpu_config.svh"

module tb_mem_stage import mem_pkg::*; ();

    logic        clk;
    logic        reset;
    logic        ws_allowin;
    logic        ms_allowin;
    logic        es_to_ms_valid;
    es_to_ms_t   es_to_ms_bus;
    logic        ms_to_ws_valid;
    ms_to_ws_t   ms_to_ws_bus;
    logic        data_sram_data_ok;
    logic [31:0] data_sram_rdata;
    logic [4:0]  mem_dest;
    logic [31:0] mem_dest_data;
    logic        ms_load_op;
    logic        inst_mfc0;
    logic        inst_mtc0;
    logic        ws_ex;
    logic        eret;
    logic        ms_ex;
    logic        ms_eret;
    integer      seed;

    mem_stage UUT (
        .clk               (clk),
        .reset             (reset),
        .ws_allowin        (ws_allowin),
        .ms_allowin        (ms_allowin),
        .es_to_ms_valid    (es_to_ms_valid),
        .es_to_ms_bus      (es_to_ms_bus),
        .ms_to_ws_valid    (ms_to_ws_valid),
        .ms_to_ws_bus      (ms_to_ws_bus),
        .data_sram_data_ok (data_sram_data_ok),
        .data_sram_rdata   (data_sram_rdata),
        .mem_dest          (mem_dest),
        .mem_dest_data     (mem_dest_data),
        .ms_load_op        (ms_load_op),
        .inst_mfc0         (inst_mfc0),
        .inst_mtc0         (inst_mtc0),
        .ws_ex             (ws_ex),
        .eret              (eret),
        .ms_ex             (ms_ex),
        .ms_eret           (ms_eret)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    task automatic fail_run(input string why);
        $display("%s", why);
        $display("=== FAIL ===");
        $fatal(1, "stopped at first error");
    endtask

    task automatic check(input logic [31:0] got, input logic [31:0] exp, input string what);
        if (got !== exp) begin
            fail_run($sformatf("MISMATCH at %0t ns: %s, got %h, expected %h",
                $time, what, got, exp));
        end
    endtask

    // expected load result, worked out from byte lanes and shifts
    function automatic logic [31:0] load_model(input ld_kind_t kind, input logic [1:0] off,
                                               input logic [31:0] rt, input logic [31:0] rd);
        logic [31:0] byte_v;
        logic [31:0] half_v;
        int          sh;
        byte_v = (rd >> (8 * int'(off))) & 32'h0000_00ff;
        half_v = (rd >> (16 * int'(off[1]))) & 32'h0000_ffff;
        case (kind)
            LD_B:    return byte_v[7] ? (byte_v | 32'hffff_ff00) : byte_v;
            LD_BU:   return byte_v;
            LD_H:    return half_v[15] ? (half_v | 32'hffff_0000) : half_v;
            LD_HU:   return half_v;
            LD_WL: begin
                sh = 24 - 8 * int'(off);
                return (rd << sh) | (rt & ((32'h1 << sh) - 32'h1));
            end
            LD_WR: begin
                sh = 8 * int'(off);
                return (rd >> sh) | (rt & ~(32'hffff_ffff >> sh));
            end
            default: return rd;
        endcase
    endfunction

    function automatic es_to_ms_t alu_bus();
        es_to_ms_t b;
        b = '0;
        b.ex_code    = `NO_EX;
        b.ld_kind    = LD_WORD;
        b.gr_we      = 1'b1;
        b.dest       = 5'($random(seed)) | 5'd1;
        b.alu_result = $random(seed);
        b.pc         = $random(seed) & 32'hffff_fffc;
        return b;
    endfunction

    // present one entry and return on the edge that takes it
    task automatic send(input es_to_ms_t b);
        int n;
        @(posedge clk);
        es_to_ms_valid <= 1'b1;
        es_to_ms_bus   <= b;
        n = 0;
        @(negedge clk);
        while (!ms_allowin) begin
            n++;
            if (n > 50) begin
                fail_run("timeout: stage never accepted the instruction");
            end
            @(negedge clk);
        end
        @(posedge clk);
        es_to_ms_valid <= 1'b0;
    endtask

    // sram answer after a chosen number of idle cycles
    task automatic sram_respond(input int delay, input logic [31:0] rd);
        int i;
        for (i = 0; i < delay; i++) begin
            @(negedge clk);
            check(32'(ms_to_ws_valid), 32'd0, "output valid before data_ok");
            check(32'(ms_allowin), 32'd0, "allowin before data_ok");
            check(32'(ms_load_op), 32'd1, "load_op while waiting");
            @(posedge clk);
        end
        data_sram_data_ok <= 1'b1;
        data_sram_rdata   <= rd;
    endtask

    task automatic run_load(input ld_kind_t kind, input int off, input int delay);
        es_to_ms_t   b;
        logic [31:0] rd;
        b = alu_bus();
        b.mem_access   = 1'b1;
        b.res_from_mem = 1'b1;
        b.ld_kind      = kind;
        b.ld_offset    = 2'(off);
        b.rt_value     = $random(seed);
        rd = $random(seed);
        send(b);
        sram_respond(delay, rd);
        @(negedge clk);
        check(32'(ms_to_ws_valid), 32'd1, "output valid on data_ok");
        check(32'(ms_load_op), 32'd1, "load_op on data_ok");
        check(ms_to_ws_bus.final_result, load_model(kind, 2'(off), b.rt_value, rd),
            $sformatf("load kind %0d offset %0d", kind, off));
        @(posedge clk);
        data_sram_data_ok <= 1'b0;
    endtask

    task automatic reset_state();
        @(negedge clk);
        check(32'(ms_allowin), 32'd1, "allowin after reset");
        check(32'(ms_to_ws_valid), 32'd0, "output valid after reset");
        check(32'(mem_dest), 32'd0, "mem_dest after reset");
        check(32'(ms_ex), 32'd0, "ms_ex after reset");
        check(32'(ms_eret), 32'd0, "ms_eret after reset");
        check(32'(inst_mtc0), 32'd0, "inst_mtc0 after reset");
    endtask

    task automatic alu_passthrough();
        es_to_ms_t b;
        b = alu_bus();
        // fields this stage only carries to writeback
        b.refill     = 1'b1;
        b.rd         = 5'($random(seed));
        b.inst_tlbr  = 1'b1;
        b.inst_tlbwi = 1'b1;
        b.pc_error   = 1'b1;
        b.slot       = 1'b1;
        b.bad_vaddr  = $random(seed);
        send(b);
        @(negedge clk);
        check(32'(ms_to_ws_valid), 32'd1, "alu output valid");
        check(ms_to_ws_bus.final_result, b.alu_result, "alu final_result");
        check(32'(ms_to_ws_bus.dest), 32'(b.dest), "alu dest");
        check(ms_to_ws_bus.pc, b.pc, "alu pc");
        check(mem_dest_data, b.alu_result, "alu forwarded data");
        check(32'(ms_to_ws_bus.gr_we), 32'd1, "alu gr_we");
        check(32'(ms_to_ws_bus.rd), 32'(b.rd), "alu rd");
        check(32'(ms_to_ws_bus.refill), 32'd1, "alu refill");
        check(32'(ms_to_ws_bus.inst_tlbr), 32'd1, "alu tlbr");
        check(32'(ms_to_ws_bus.inst_tlbwi), 32'd1, "alu tlbwi");
        check(32'(ms_to_ws_bus.pc_error), 32'd1, "alu pc_error");
        check(32'(ms_to_ws_bus.slot), 32'd1, "alu slot");
        check(ms_to_ws_bus.bad_vaddr, b.bad_vaddr, "alu bad_vaddr");
        @(posedge clk);
        @(negedge clk);
        check(32'(ms_to_ws_valid), 32'd0, "stage empty after alu");
    endtask

    task automatic load_formats();
        int k;
        int o;
        for (k = 0; k < 7; k++) begin
            for (o = 0; o < 4; o++) begin
                run_load(ld_kind_t'(k), o, 0);
            end
        end
    endtask

    task automatic load_latency();
        int d;
        for (d = 0; d <= 4; d++) begin
            run_load(ld_kind_t'(d + 2), d % 4, d);
        end
    endtask

    task automatic backpressure();
        es_to_ms_t a;
        es_to_ms_t c;
        a = alu_bus();
        c = alu_bus();
        @(posedge clk);
        ws_allowin <= 1'b0;
        send(a);
        // next one waits behind the stalled entry
        es_to_ms_valid <= 1'b1;
        es_to_ms_bus   <= c;
        repeat (4) begin
            @(negedge clk);
            check(32'(ms_to_ws_valid), 32'd1, "valid while stalled");
            check(32'(ms_allowin), 32'd0, "allowin while stalled");
            check(ms_to_ws_bus.pc, a.pc, "pc while stalled");
            check(ms_to_ws_bus.final_result, a.alu_result, "result while stalled");
            @(posedge clk);
        end
        ws_allowin <= 1'b1;
        @(negedge clk);
        check(ms_to_ws_bus.pc, a.pc, "first entry on release");
        check(32'(ms_allowin), 32'd1, "allowin on release");
        @(posedge clk);
        es_to_ms_valid <= 1'b0;
        @(negedge clk);
        check(32'(ms_to_ws_valid), 32'd1, "second entry valid");
        check(ms_to_ws_bus.pc, c.pc, "second entry pc");
        @(posedge clk);
        @(negedge clk);
        check(32'(ms_to_ws_valid), 32'd0, "no duplicate after release");
    endtask

    task automatic flush_entry(input logic use_eret);
        es_to_ms_t b;
        b = alu_bus();
        b.mem_access   = 1'b1;
        b.res_from_mem = 1'b1;
        b.dest         = 5'd9;
        send(b);
        if (use_eret) begin
            eret <= 1'b1;
        end else begin
            ws_ex <= 1'b1;
        end
        @(negedge clk);
        check(32'(mem_dest), 32'd9, "dest held before flush");
        check(32'(ms_to_ws_valid), 32'd0, "no output before flush");
        @(posedge clk);
        ws_ex <= 1'b0;
        eret  <= 1'b0;
        repeat (3) begin
            @(negedge clk);
            check(32'(ms_to_ws_valid), 32'd0, "output after flush");
            check(32'(mem_dest), 32'd0, "mem_dest after flush");
        end
        check(32'(ms_allowin), 32'd1, "allowin after flush");
    endtask

    task automatic cp0_flags();
        es_to_ms_t b;
        b = alu_bus();
        b.ex_code   = 5'h0c;
        b.inst_mfc0 = 1'b1;
        b.inst_mtc0 = 1'b1;
        send(b);
        @(negedge clk);
        check(32'(ms_ex), 32'd1, "ms_ex with ex_code");
        check(32'(inst_mfc0), 32'd1, "mfc0 while valid");
        check(32'(inst_mtc0), 32'd1, "mtc0 while valid");
        check(32'(ms_to_ws_bus.ex_code), 32'h0c, "ex_code to writeback");
        check(32'(ms_to_ws_bus.inst_mfc0), 32'd1, "mfc0 to writeback");
        check(32'(ms_to_ws_bus.inst_mtc0), 32'd1, "mtc0 to writeback");
        @(posedge clk);
        @(negedge clk);
        check(32'(inst_mfc0), 32'd0, "mfc0 once drained");
        check(32'(inst_mtc0), 32'd0, "mtc0 once drained");
        b = alu_bus();
        b.eret = 1'b1;
        send(b);
        @(negedge clk);
        check(32'(ms_eret), 32'd1, "ms_eret with eret entry");
        check(32'(ms_ex), 32'd0, "ms_ex without ex_code");
        check(32'(ms_to_ws_bus.eret), 32'd1, "eret to writeback");
        @(posedge clk);
    endtask

    initial begin
        seed              = 32'hbb931137;
        reset             = 1'b1;
        ws_allowin        = 1'b1;
        es_to_ms_valid    = 1'b0;
        es_to_ms_bus      = '0;
        data_sram_data_ok = 1'b0;
        data_sram_rdata   = '0;
        ws_ex             = 1'b0;
        eret              = 1'b0;
        repeat (8) @(posedge clk);
        reset <= 1'b0;
        reset_state();
        alu_passthrough();
        load_formats();
        load_latency();
        backpressure();
        flush_entry(1'b0);
        flush_entry(1'b1);
        cp0_flags();
        @(posedge clk);
        $display("=== PASS ===");
        $finish;
    end

endmodule
